/* source/accel_pkg.sv */
package accel_pkg;

	// --------------------
	// datapath widths
	typedef logic [31:0] word_t;        // bus and FIFO word
	typedef logic [7:0]  pixel_t;       // unsigned pixel
	typedef logic [15:0] result_t;      // pooled result
	typedef logic [15:0] win_count_t;   // windows per command

	localparam int PIXELS_PER_WORD = 4; // one 2x2 window per word

	// --------------------
	// operations
	typedef enum logic [2:0] {
		OP_NONE    = 3'd0,
		OP_MAXPOOL = 3'd1,
		OP_AVEPOOL = 3'd2
	} op_type_e;

	typedef struct packed {
		win_count_t  count;   // bits 31..16
		logic [12:0] rsvd;
		logic [2:0]  op_code; // raw code, may be invalid
	} cmd_t;

	typedef struct packed {
		op_type_e   op_type;
		win_count_t count;
	} op_t;

	typedef struct packed {
		result_t data;
		logic    last; // final window of the command
	} res_beat_t;

endpackage

/* source/host_bus_pkg.sv */
package host_bus_pkg;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [2:0]  adr;
		logic [31:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

	// --------------------
	// register map
	typedef enum logic [2:0] {
		REG_CTRL   = 3'd0,
		REG_STATUS = 3'd1,
		REG_CMD    = 3'd2,
		REG_DATA   = 3'd3,
		REG_RESULT = 3'd4
	} reg_addr_e;

	localparam int CTRL_OP_EN = 0;    // enable command fetch
	localparam int CTRL_CLEAR = 1;    // flush FIFOs and counters, self-clearing

	localparam int ST_IN_READY  = 0;
	localparam int ST_OUT_READY = 1;
	localparam int ST_CMD_EMPTY = 2;
	localparam int ST_RES_EMPTY = 3;
	localparam int ST_BUSY      = 4;
	localparam int ST_ERROR     = 5;
	localparam int ST_OPS_LSB   = 16; // ops_done in 31..16

endpackage

/* source/sync_fifo.sv */
`timescale 1ns/100ps

module sync_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 1024
) (
	input  logic                     okClk,
	input  logic                     rst,
	input  logic                     clear,
	input  logic                     wr_en,
	input  logic [WIDTH-1:0]         din,
	input  logic                     rd_en,
	output logic [WIDTH-1:0]         dout,
	output logic                     empty,
	output logic                     full,
	output logic [$clog2(DEPTH):0]   count
);

	localparam int AW = $clog2(DEPTH);

	logic [WIDTH-1:0] mem [DEPTH];
	logic [AW-1:0]    wr_ptr;
	logic [AW-1:0]    rd_ptr;
	logic             do_wr;
	logic             do_rd;

	assign do_wr = wr_en && !full;  // pushes on a full FIFO are dropped
	assign do_rd = rd_en && !empty;
	assign empty = (count == '0);
	assign full  = (count == (AW+1)'(DEPTH));
	assign dout  = mem[rd_ptr];     // show-ahead head word

	always_ff @(posedge okClk) begin
		if (rst || clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_wr) wr_ptr <= wr_ptr + 1'b1; // wraps at DEPTH
			if (do_rd) rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (do_wr) mem[wr_ptr] <= din;
	end

endmodule

/* source/host_port.sv */
`timescale 1ns/100ps

module host_port #(
	parameter int FIFO_DEPTH      = 1024,
	parameter int BLOCK_SIZE      = 128,
	parameter int BUFFER_HEADROOM = 20
) (
	input  logic                        okClk,
	input  logic                        rst,
	input  host_bus_pkg::wb_req_t       wb_req,
	output host_bus_pkg::wb_rsp_t       wb_rsp,
	output logic                        op_en,
	output logic                        clear,
	output logic                        cmd_wr,
	output logic                        data_wr,
	output accel_pkg::word_t            wr_word,
	input  logic                        cmd_full,
	input  logic                        data_full,
	input  logic [$clog2(FIFO_DEPTH):0] data_count,
	input  logic [$clog2(FIFO_DEPTH):0] result_count,
	input  logic                        cmd_empty,
	input  logic                        result_empty,
	output logic                        result_rd,
	input  accel_pkg::word_t            result_word,
	input  logic                        busy,
	input  logic                        error,
	input  accel_pkg::win_count_t       ops_done
);

	localparam int CW = $clog2(FIFO_DEPTH) + 1;
	localparam logic [CW-1:0] IN_LIMIT  = CW'(FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE);
	localparam logic [CW-1:0] OUT_LIMIT = CW'(BLOCK_SIZE);

	host_bus_pkg::reg_addr_e addr;
	logic                    access;
	logic                    is_wr;
	logic                    stall;
	logic                    ack_q;
	logic                    in_ready;
	logic                    out_ready;
	accel_pkg::word_t        dat_q;
	accel_pkg::word_t        status;

	// --------------------
	// bus decode
	assign addr    = host_bus_pkg::reg_addr_e'(wb_req.adr);
	assign access  = wb_req.cyc && wb_req.stb && !ack_q; // one action per strobe
	assign is_wr   = access && wb_req.we;
	assign stall   = is_wr && ((addr == host_bus_pkg::REG_CMD && cmd_full) ||
		(addr == host_bus_pkg::REG_DATA && data_full)); // wait states until space frees
	assign cmd_wr  = is_wr && (addr == host_bus_pkg::REG_CMD) && !cmd_full;
	assign data_wr = is_wr && (addr == host_bus_pkg::REG_DATA) && !data_full;
	assign wr_word = wb_req.dat;
	assign result_rd = access && !wb_req.we && (addr == host_bus_pkg::REG_RESULT) &&
		!result_empty;
	assign wb_rsp  = '{ack: ack_q, dat: dat_q};

	always_comb begin
		status = '0;
		status[host_bus_pkg::ST_IN_READY]  = in_ready;
		status[host_bus_pkg::ST_OUT_READY] = out_ready;
		status[host_bus_pkg::ST_CMD_EMPTY] = cmd_empty;
		status[host_bus_pkg::ST_RES_EMPTY] = result_empty;
		status[host_bus_pkg::ST_BUSY]      = busy;
		status[host_bus_pkg::ST_ERROR]     = error;
		status[host_bus_pkg::ST_OPS_LSB +: $bits(accel_pkg::win_count_t)] = ops_done;
	end

	// --------------------
	// control and throttle
	always_ff @(posedge okClk) begin
		if (rst) begin
			ack_q     <= 1'b0;
			op_en     <= 1'b0;
			clear     <= 1'b0;
			in_ready  <= 1'b1;
			out_ready <= 1'b0;
		end else begin
			ack_q <= access && !stall;
			clear <= is_wr && (addr == host_bus_pkg::REG_CTRL) &&
				wb_req.dat[host_bus_pkg::CTRL_CLEAR]; // one-cycle pulse
			if (is_wr && addr == host_bus_pkg::REG_CTRL) op_en <= wb_req.dat[host_bus_pkg::CTRL_OP_EN];
			in_ready  <= (data_count <= IN_LIMIT);    // room for another block
			out_ready <= (result_count >= OUT_LIMIT); // a full block waiting
		end
	end

	always_ff @(posedge okClk) begin
		if (access && !wb_req.we) begin
			case (addr)
				host_bus_pkg::REG_CTRL:   dat_q <= accel_pkg::word_t'(op_en);
				host_bus_pkg::REG_STATUS: dat_q <= status;
				host_bus_pkg::REG_RESULT: dat_q <= result_empty ? '0 : result_word; // zero when empty
				default:                  dat_q <= '0;
			endcase
		end
	end

endmodule

/* source/op_sequencer.sv */
`timescale 1ns/100ps

module op_sequencer (
	input  logic                  okClk,
	input  logic                  rst,
	input  logic                  clear,
	input  logic                  op_en,
	input  accel_pkg::cmd_t       cmd_head,
	input  logic                  cmd_empty,
	output logic                  cmd_rd,
	output accel_pkg::op_t        op,
	output logic                  op_valid,
	input  logic                  op_ready,
	input  logic                  op_done,
	output logic                  busy,
	output logic                  error,
	output accel_pkg::win_count_t ops_done
);

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT
	} state_e;

	state_e state;
	logic   cmd_ok;

	// known pooling type with a non-zero window count
	assign cmd_ok = ((cmd_head.op_code == accel_pkg::OP_MAXPOOL) ||
		(cmd_head.op_code == accel_pkg::OP_AVEPOOL)) && (cmd_head.count != '0);

	assign cmd_rd   = (state == IDLE) && op_en && !cmd_empty; // fetch pops the head
	assign op_valid = (state == ISSUE);
	assign busy     = (state != IDLE);

	always_ff @(posedge okClk) begin
		if (rst || clear) begin
			state    <= IDLE;
			error    <= 1'b0;
			ops_done <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (cmd_rd) begin
						if (cmd_ok) begin
							state <= ISSUE;
						end else begin
							error    <= 1'b1;              // sticky until clear
							ops_done <= ops_done + 1'b1; // bad command still counts as done
						end
					end
				end
				ISSUE: if (op_ready) state <= WAIT;
				WAIT: begin
					if (op_done) begin
						state    <= IDLE;
						ops_done <= ops_done + 1'b1;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge okClk) begin
		if (cmd_rd) begin
			op.op_type <= accel_pkg::op_type_e'(cmd_head.op_code);
			op.count   <= cmd_head.count;
		end
	end

endmodule

/* source/pool_engine.sv */
`timescale 1ns/100ps

module pool_engine (
	input  logic                 okClk,
	input  logic                 rst,
	input  logic                 clear,
	input  accel_pkg::op_t       op,
	input  logic                 op_valid,
	output logic                 op_ready,
	input  accel_pkg::word_t     data_head,
	input  logic                 data_empty,
	output logic                 data_rd,
	output accel_pkg::res_beat_t res,
	output logic                 res_valid,
	input  logic                 res_ready,
	output logic                 op_done
);

	localparam int AVE_SHIFT = $clog2(accel_pkg::PIXELS_PER_WORD);
	localparam int PIX_W     = $bits(accel_pkg::pixel_t);
	localparam int SUM_W     = PIX_W + AVE_SHIFT;

	accel_pkg::op_t        op_q;
	accel_pkg::win_count_t popped;     // windows taken from the data FIFO
	logic                  active;
	accel_pkg::word_t      s1_word;
	logic                  s1_valid;
	logic                  s1_last;
	accel_pkg::pixel_t     pix;
	accel_pkg::pixel_t     max_px;
	logic [SUM_W-1:0]      sum;
	accel_pkg::result_t    reduced;

	assign op_ready = !active;  // pipeline drained between commands
	assign data_rd  = active && (popped != op_q.count) && !data_empty && res_ready;
	assign op_done  = res_valid && res_ready && res.last;

	// --------------------
	// window reduction
	always_comb begin
		max_px = '0;
		sum    = '0;
		for (int i = 0; i < accel_pkg::PIXELS_PER_WORD; i++) begin
			pix = s1_word[i*PIX_W +: PIX_W];
			sum = sum + SUM_W'(pix);
			if (pix > max_px) max_px = pix;
		end
		if (op_q.op_type == accel_pkg::OP_AVEPOOL) reduced = accel_pkg::result_t'(sum >> AVE_SHIFT);
		else reduced = accel_pkg::result_t'(max_px);
	end

	always_ff @(posedge okClk) begin
		if (rst || clear) begin
			active    <= 1'b0;
			popped    <= '0;
			s1_valid  <= 1'b0;
			res_valid <= 1'b0;
		end else begin
			if (op_valid && op_ready) begin
				active <= 1'b1;
				popped <= '0;
			end else if (op_done) begin
				active <= 1'b0;
			end
			if (data_rd) popped <= popped + 1'b1;
			if (res_ready) begin // both stages stall together
				s1_valid  <= data_rd;
				res_valid <= s1_valid;
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (op_valid && op_ready) op_q <= op;
		if (res_ready) begin
			s1_word  <= data_head;
			s1_last  <= (popped == op_q.count - 1'b1);
			res.data <= reduced;
			res.last <= s1_last;
		end
	end

endmodule

/* source/result_packer.sv */
`timescale 1ns/100ps

module result_packer (
	input  logic                 okClk,
	input  logic                 rst,
	input  logic                 clear,
	input  accel_pkg::res_beat_t res,
	input  logic                 res_valid,
	output logic                 res_ready,
	input  logic                 fifo_full,
	output logic                 fifo_wr,
	output accel_pkg::word_t     fifo_word
);

	accel_pkg::result_t low_q;     // first result of a pair
	logic               low_valid;
	logic               accept;

	assign res_ready = !fifo_full;
	assign accept    = res_valid && res_ready;

	always_ff @(posedge okClk) begin
		if (rst || clear) begin
			low_valid <= 1'b0;
			fifo_wr   <= 1'b0;
		end else begin
			fifo_wr <= 1'b0;
			if (accept) begin
				if (low_valid) begin
					fifo_wr   <= 1'b1; // pair complete
					low_valid <= 1'b0;
				end else if (res.last) begin
					fifo_wr <= 1'b1;     // flush lone result
				end else begin
					low_valid <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge okClk) begin
		if (accept) begin
			if (low_valid) begin
				fifo_word <= {res.data, low_q}; // low half first
			end else begin
				fifo_word <= {accel_pkg::result_t'(0), res.data};
				low_q     <= res.data;
			end
		end
	end

endmodule

/* source/accel_top.sv */
`timescale 1ns/100ps

module accel_top #(
	parameter int FIFO_DEPTH      = 1024,
	parameter int BLOCK_SIZE      = 128,
	parameter int BUFFER_HEADROOM = 20
) (
	input  logic                  okClk,
	input  logic                  rst,
	input  host_bus_pkg::wb_req_t wb_req,
	output host_bus_pkg::wb_rsp_t wb_rsp
);

	localparam int CW = $clog2(FIFO_DEPTH) + 1;
	localparam int WW = $bits(accel_pkg::word_t);

	logic                  op_en, clear;
	logic                  cmd_wr, cmd_rd, cmd_full, cmd_empty;
	logic                  data_wr, data_rd, data_full, data_empty;
	logic                  result_rd, result_full, result_empty;
	logic [CW-1:0]         data_count, result_count;
	accel_pkg::word_t      wr_word, data_head, result_word, fifo_word;
	accel_pkg::cmd_t       cmd_head;
	accel_pkg::op_t        op;
	logic                  op_valid, op_ready, op_done;
	accel_pkg::res_beat_t  res;
	logic                  res_valid, res_ready, fifo_wr;
	logic                  busy, error;
	accel_pkg::win_count_t ops_done;

	// --------------------
	// input side
	host_port #(
		.FIFO_DEPTH(FIFO_DEPTH), .BLOCK_SIZE(BLOCK_SIZE), .BUFFER_HEADROOM(BUFFER_HEADROOM)
	) u_host_port (
		.okClk(okClk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp),
		.op_en(op_en), .clear(clear), .cmd_wr(cmd_wr), .data_wr(data_wr), .wr_word(wr_word),
		.cmd_full(cmd_full), .data_full(data_full),
		.data_count(data_count), .result_count(result_count),
		.cmd_empty(cmd_empty), .result_empty(result_empty),
		.result_rd(result_rd), .result_word(result_word),
		.busy(busy), .error(error), .ops_done(ops_done)
	);

	sync_fifo #(.WIDTH(WW), .DEPTH(FIFO_DEPTH)) cmd_fifo (
		.okClk(okClk), .rst(rst), .clear(clear),
		.wr_en(cmd_wr), .din(wr_word), .rd_en(cmd_rd), .dout(cmd_head),
		.empty(cmd_empty), .full(cmd_full), .count()
	);

	sync_fifo #(.WIDTH(WW), .DEPTH(FIFO_DEPTH)) data_fifo (
		.okClk(okClk), .rst(rst), .clear(clear),
		.wr_en(data_wr), .din(wr_word), .rd_en(data_rd), .dout(data_head),
		.empty(data_empty), .full(data_full), .count(data_count)
	);

	// --------------------
	// processing
	op_sequencer u_op_sequencer (
		.okClk(okClk), .rst(rst), .clear(clear), .op_en(op_en),
		.cmd_head(cmd_head), .cmd_empty(cmd_empty), .cmd_rd(cmd_rd),
		.op(op), .op_valid(op_valid), .op_ready(op_ready), .op_done(op_done),
		.busy(busy), .error(error), .ops_done(ops_done)
	);

	pool_engine u_pool_engine (
		.okClk(okClk), .rst(rst), .clear(clear),
		.op(op), .op_valid(op_valid), .op_ready(op_ready),
		.data_head(data_head), .data_empty(data_empty), .data_rd(data_rd),
		.res(res), .res_valid(res_valid), .res_ready(res_ready), .op_done(op_done)
	);

	// --------------------
	// output side
	result_packer u_result_packer (
		.okClk(okClk), .rst(rst), .clear(clear),
		.res(res), .res_valid(res_valid), .res_ready(res_ready),
		.fifo_full(result_full), .fifo_wr(fifo_wr), .fifo_word(fifo_word)
	);

	sync_fifo #(.WIDTH(WW), .DEPTH(FIFO_DEPTH)) result_fifo (
		.okClk(okClk), .rst(rst), .clear(clear),
		.wr_en(fifo_wr), .din(fifo_word), .rd_en(result_rd), .dout(result_word),
		.empty(result_empty), .full(result_full), .count(result_count)
	);

endmodule

/* verification/accel_checker.sv */
`timescale 1ns/100ps

module accel_checker (
	input logic                  okClk,
	input logic                  rst,
	input logic                  clear,
	input host_bus_pkg::wb_req_t wb_req,
	input host_bus_pkg::wb_rsp_t wb_rsp,
	input accel_pkg::res_beat_t  res,
	input logic                  res_valid,
	input logic                  res_ready,
	input logic                  cmd_wr,
	input logic                  cmd_full,
	input logic                  data_wr,
	input logic                  data_full,
	input logic                  fifo_wr,
	input logic                  result_full
);

	// ack only inside an active bus cycle
	ack_in_cycle: assert property (@(posedge okClk) disable iff (rst)
		wb_rsp.ack |-> wb_req.cyc && wb_req.stb)
		else $error("ack raised outside an active bus cycle");

	// a stalled result beat must not change
	res_held: assert property (@(posedge okClk) disable iff (rst || clear)
		res_valid && !res_ready |=> res_valid && $stable(res))
		else $error("result beat changed while res_ready was low");

	no_push_when_full: assert property (@(posedge okClk) disable iff (rst)
		!((cmd_wr && cmd_full) || (data_wr && data_full) || (fifo_wr && result_full)))
		else $error("FIFO write while that FIFO was full");

endmodule

bind accel_top accel_checker u_accel_checker (
	.okClk(okClk), .rst(rst), .clear(clear), .wb_req(wb_req), .wb_rsp(wb_rsp),
	.res(res), .res_valid(res_valid), .res_ready(res_ready),
	.cmd_wr(cmd_wr), .cmd_full(cmd_full), .data_wr(data_wr), .data_full(data_full),
	.fifo_wr(fifo_wr), .result_full(result_full)
);

/* verification/tb_accel_top.sv */
`timescale 1ns/100ps

module tb_accel_top;

	localparam int FIFO_DEPTH      = 64;
	localparam int BLOCK_SIZE      = 8;
	localparam int BUFFER_HEADROOM = 4;
	localparam int N_ROWS          = 8;
	localparam int IN_LIMIT        = FIFO_DEPTH - BUFFER_HEADROOM - BLOCK_SIZE; // 52 words
	localparam int STALL_WINDOWS   = 2 * FIFO_DEPTH + 12; // more results than the result FIFO holds

	typedef struct packed {
		logic [2:0]  op_code;
		logic [15:0] count;
		logic [7:0]  exp_words; // result words the command leaves in the FIFO
		logic        exp_err;   // sticky error once the command is done
	} row_t;

	logic                  okClk = 1'b0;
	logic                  rst;
	host_bus_pkg::wb_req_t wb_req;
	host_bus_pkg::wb_rsp_t wb_rsp;
	logic [31:0]           lfsr = 32'h28d10c63;
	logic [31:0]           windows [$];   // window words of the current command
	int                    errors = 0;
	int                    checks = 0;
	int                    cycles = 0;
	int                    cycle_limit = 0;

	row_t stim [N_ROWS] = '{
		'{3'd1, 16'd6,  8'd3, 1'b0},  // maxpool, three pairs
		'{3'd2, 16'd5,  8'd3, 1'b0},  // avepool, lone last result
		'{3'd1, 16'd1,  8'd1, 1'b0},
		'{3'd1, 16'd16, 8'd8, 1'b0},  // exactly one block
		'{3'd2, 16'd14, 8'd7, 1'b0},  // one word short of a block
		'{3'd5, 16'd3,  8'd0, 1'b1},  // unknown op type
		'{3'd1, 16'd0,  8'd0, 1'b1},  // zero windows
		'{3'd2, 16'd3,  8'd2, 1'b1}   // error stays set
	};

	accel_top #(
		.FIFO_DEPTH(FIFO_DEPTH), .BLOCK_SIZE(BLOCK_SIZE), .BUFFER_HEADROOM(BUFFER_HEADROOM)
	) u_accel_top (
		.okClk(okClk), .rst(rst), .wb_req(wb_req), .wb_rsp(wb_rsp)
	);

	always #10 okClk = ~okClk;

	always @(posedge okClk) begin
		cycles = cycles + 1;
		if (cycle_limit != 0 && cycles >= cycle_limit) begin
			$display("timeout: the run did not finish within %0d cycles", cycle_limit);
			$display("TB FAILED");
			$finish;
		end
	end

	// --------------------
	// stimulus and reference
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32, 22, 2, 1
	endfunction

	task automatic random_word(output logic [31:0] w);
		w = '0;
		for (int i = 0; i < 32; i++) begin
			lfsr = lfsr_next(lfsr);
			w    = {w[30:0], lfsr[0]};
		end
	endtask

	// max of the four pixels, or their floored mean
	function automatic logic [15:0] pool_ref(input logic [2:0] op_code, input logic [31:0] w);
		logic [7:0] px;
		logic [7:0] top;
		int         total;
		top   = '0;
		total = 0;
		for (int i = 0; i < 4; i++) begin
			px    = w[8*i +: 8];
			total = total + int'(px);
			if (px > top) top = px;
		end
		if (op_code == accel_pkg::OP_AVEPOOL) return 16'(total / 4);
		return {8'd0, top};
	endfunction

	function automatic logic [31:0] status_word(input logic [15:0] ops, input logic err,
		input logic res_e, input logic cmd_e, input logic out_r, input logic in_r);
		logic [31:0] w;
		w = '0; // busy left low
		w[host_bus_pkg::ST_IN_READY]      = in_r;
		w[host_bus_pkg::ST_OUT_READY]     = out_r;
		w[host_bus_pkg::ST_CMD_EMPTY]     = cmd_e;
		w[host_bus_pkg::ST_RES_EMPTY]     = res_e;
		w[host_bus_pkg::ST_ERROR]         = err;
		w[host_bus_pkg::ST_OPS_LSB +: 16] = ops;
		return w;
	endfunction

	// --------------------
	// bus access
	task automatic bus_write(input host_bus_pkg::reg_addr_e adr, input logic [31:0] dat);
		@(negedge okClk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
		do begin
			@(negedge okClk);
		end while (!wb_rsp.ack); // full FIFO stretches the wait
		@(negedge okClk);        // request held over the edge that takes ack
		wb_req = '0;
	endtask

	task automatic bus_read(input host_bus_pkg::reg_addr_e adr, output logic [31:0] dat);
		@(negedge okClk);
		wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'd0};
		do begin
			@(negedge okClk);
		end while (!wb_rsp.ack);
		dat = wb_rsp.dat;
		@(negedge okClk);
		wb_req = '0;
	endtask

	task automatic read_status(output logic [31:0] st);
		repeat (3) @(negedge okClk); // let the registered flags settle
		bus_read(host_bus_pkg::REG_STATUS, st);
	endtask

	task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	initial begin : main
		logic [31:0] st;
		logic [31:0] word;
		logic [31:0] exp;
		logic [15:0] ops_before;
		row_t        row;
		foreach (stim[r]) cycle_limit += 200 * int'(stim[r].count);
		cycle_limit += 2000;
		rst    = 1'b1;
		wb_req = '0;
		repeat (3) @(posedge okClk);
		@(negedge okClk);
		rst = 1'b0;
		expect_eq("ack after reset", 32'(wb_rsp.ack), 32'd0);
		read_status(st);
		expect_eq("status after reset", st, status_word(16'd0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1));

		// --------------------
		// input throttle with op_en off
		for (int i = 0; i < IN_LIMIT; i++) begin
			bus_write(host_bus_pkg::REG_DATA, 32'(i));
		end
		read_status(st);
		expect_eq("status at data limit", st, status_word(16'd0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1));
		bus_write(host_bus_pkg::REG_DATA, 32'hffff_ffff);
		read_status(st);
		expect_eq("status past data limit", st, status_word(16'd0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0));
		bus_write(host_bus_pkg::REG_CTRL, 32'h2);
		read_status(st);
		expect_eq("status after clear", st, status_word(16'd0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1));
		bus_write(host_bus_pkg::REG_CTRL, 32'h1);

		// --------------------
		// command table
		foreach (stim[r]) begin
			row = stim[r];
			read_status(st);
			ops_before = st[31:16];
			windows.delete();
			if (row.exp_words != 8'd0) begin
				for (int i = 0; i < int'(row.count); i++) begin
					random_word(word);
					windows.push_back(word);
					bus_write(host_bus_pkg::REG_DATA, word);
				end
			end
			bus_write(host_bus_pkg::REG_CMD, {row.count, 13'd0, row.op_code});
			do begin
				bus_read(host_bus_pkg::REG_STATUS, st);
			end while (st[31:16] == ops_before);
			read_status(st);
			expect_eq($sformatf("row %0d status", r), st, status_word(ops_before + 16'd1,
				row.exp_err, row.exp_words == 8'd0, 1'b1,
				int'(row.exp_words) >= BLOCK_SIZE, 1'b1));
			for (int k = 0; k < int'(row.exp_words); k++) begin
				exp = {16'd0, pool_ref(row.op_code, windows[2*k])};
				if (2*k + 1 < windows.size()) exp[31:16] = pool_ref(row.op_code, windows[2*k+1]);
				bus_read(host_bus_pkg::REG_RESULT, word);
				expect_eq($sformatf("row %0d result word %0d", r, k), word, exp);
			end
		end

		// --------------------
		// result FIFO runs full and stalls the engine
		read_status(st);
		ops_before = st[31:16];
		windows.delete();
		bus_write(host_bus_pkg::REG_CMD, {16'(STALL_WINDOWS), 13'd0, 3'd1});
		for (int i = 0; i < STALL_WINDOWS; i++) begin
			random_word(word);
			windows.push_back(word);
			bus_write(host_bus_pkg::REG_DATA, word);
		end
		read_status(st);
		exp = status_word(ops_before, 1'b1, 1'b0, 1'b1, 1'b1, 1'b1);
		exp[host_bus_pkg::ST_BUSY] = 1'b1; // command still waiting for room
		expect_eq("status with result FIFO full", st, exp);
		for (int k = 0; k < STALL_WINDOWS / 2; k++) begin
			exp = {pool_ref(3'd1, windows[2*k+1]), pool_ref(3'd1, windows[2*k])};
			bus_read(host_bus_pkg::REG_RESULT, word);
			expect_eq($sformatf("stalled command result word %0d", k), word, exp);
		end
		do begin
			bus_read(host_bus_pkg::REG_STATUS, st);
		end while (st[31:16] == ops_before);
		read_status(st);
		expect_eq("status after stalled command", st,
			status_word(ops_before + 16'd1, 1'b1, 1'b1, 1'b1, 1'b0, 1'b1));

		// --------------------
		// clear with results and a command pending
		for (int i = 0; i < 4; i++) begin
			random_word(word);
			bus_write(host_bus_pkg::REG_DATA, word);
		end
		bus_write(host_bus_pkg::REG_CMD, {16'd4, 13'd0, 3'd1});
		do begin
			bus_read(host_bus_pkg::REG_STATUS, st);
		end while (st[31:16] != 16'(N_ROWS + 2));
		bus_write(host_bus_pkg::REG_CTRL, 32'h0);
		bus_write(host_bus_pkg::REG_CMD, {16'd2, 13'd0, 3'd1});
		read_status(st);
		expect_eq("status before clear", st,
			status_word(16'(N_ROWS + 2), 1'b1, 1'b0, 1'b0, 1'b0, 1'b1));
		bus_write(host_bus_pkg::REG_CTRL, 32'h2);
		read_status(st);
		expect_eq("status after final clear", st,
			status_word(16'd0, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1));
		bus_read(host_bus_pkg::REG_RESULT, word);
		expect_eq("result read on empty FIFO", word, 32'd0);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
source/accel_pkg.sv
source/host_bus_pkg.sv
source/sync_fifo.sv
source/host_port.sv
source/op_sequencer.sv
source/pool_engine.sv
source/result_packer.sv
source/accel_top.sv
verification/accel_checker.sv
verification/tb_accel_top.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_accel_top
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
